// File: sources.f
rtl/fcart_pkg.sv
rtl/chan_slot.sv
rtl/mem_arbiter.sv
rtl/mem_array.sv
rtl/fcart_mem.sv
tb/fcart_mem_asserts.sv
tb/tb_fcart_mem.sv

// File: Bender.yml
package:
  name: fcart_mem

sources:
  - files:
      - rtl/fcart_pkg.sv
      - rtl/chan_slot.sv
      - rtl/mem_arbiter.sv
      - rtl/mem_array.sv
      - rtl/fcart_mem.sv
  - target: test
    files:
      - tb/fcart_mem_asserts.sv
      - tb/tb_fcart_mem.sv

// File: tb/tb_fcart_mem.sv
module tb_fcart_mem;
    import fcart_pkg::*;

    localparam int n_rand_ops   = 240;
    localparam int n_directed   = 7;
    localparam int wd_cycles    = (n_rand_ops + n_directed) * 40 + 200;
    localparam int mem_words    = 2 ** ram_addr_bits;
    localparam int lone_latency = 5;  // accept edge to done edge.

    logic              clk;
    logic              async_nreset;
    logic              m2;
    logic [num_ch-1:0] req;
    mem_req_t          req_data [num_ch];
    logic [num_ch-1:0] done;
    logic [num_ch-1:0] busy;
    logic [7:0]        rdata [num_ch];

    logic [7:0]        model_mem [mem_words];
    bit                written [mem_words];
    int                wr_out [mem_words];
    int                rd_out [mem_words];

    bit                outstanding [num_ch];
    bit                out_we [num_ch];
    logic [7:0]        out_exp [num_ch];
    logic [ram_addr_bits-1:0] out_addr [num_ch];
    int                issue_cyc [num_ch];
    int                done_cyc [num_ch];

    logic [31:0]       rng = 32'h73fb;
    int                cyc;

    fcart_mem i_dut (
        .clk         (clk),
        .async_nreset(async_nreset),
        .m2          (m2),
        .req         (req),
        .req_data    (req_data),
        .done        (done),
        .busy        (busy),
        .rdata       (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t %s actual=%0h expected=%0h",
                     $time, name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        req <= '0;
        cyc++;
    endtask

    task automatic issue(input int c, input logic we,
                         input logic [ram_addr_bits-1:0] addr, input logic [7:0] wdata);
        req[c]      <= 1'b1;
        req_data[c] <= '{addr: addr, wdata: wdata, we: we};
        outstanding[c] = 1'b1;
        out_we[c]      = we;
        out_addr[c]    = addr;
        issue_cyc[c]   = cyc;
        if (we) begin
            model_mem[addr] = wdata;
            written[addr]   = 1'b1;
            wr_out[addr]++;
            out_exp[c] = wdata;
        end else begin
            out_exp[c] = model_mem[addr];  // value at issue time.
            rd_out[addr]++;
        end
    endtask

    function automatic bit any_outstanding();
        return outstanding[0] || outstanding[1] || outstanding[2];
    endfunction

    task automatic wait_idle();
        while (any_outstanding()) begin
            tick();
        end
    endtask

    function automatic int latency(input int c);
        return done_cyc[c] - issue_cyc[c] - 1;
    endfunction

    // m2 steady high long enough to drain any refresh.
    task automatic settle();
        m2 <= 1'b1;
        wait_idle();
        repeat (12) tick();
    endtask

    always @(negedge clk) begin
        if (async_nreset) begin
            for (int c = 0; c < num_ch; c++) begin
                // high after the accept edge up to the done cycle.
                check($sformatf("busy[%0d]", c), busy[c],
                      outstanding[c] && cyc != issue_cyc[c]);
                if (done[c] && !outstanding[c]) begin
                    abort_run($sformatf("done on channel %0d with no request", c));
                end else if (done[c]) begin
                    if (!out_we[c]) begin
                        check($sformatf("rdata[%0d]", c), rdata[c], out_exp[c]);
                        rd_out[out_addr[c]]--;
                    end else begin
                        wr_out[out_addr[c]]--;
                    end
                    outstanding[c] = 1'b0;
                    done_cyc[c]    = cyc;
                end
            end
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        abort_run("timeout: the DUT stopped completing requests");
    end

    initial begin
        int rand_issued;
        int m2_cnt;
        logic [ram_addr_bits-1:0] a;

        async_nreset = 1'b0;
        m2           = 1'b1;
        req          = '0;
        for (int c = 0; c < num_ch; c++) begin
            req_data[c] = '0;
        end
        rand_issued = 0;
        m2_cnt      = 0;

        repeat (8) tick();
        async_nreset <= 1'b1;
        tick();
        @(negedge clk);
        check("done", done, '0);
        check("busy", busy, '0);

        // lone accesses at the fixed latency.
        repeat (12) tick();
        issue(ch_cpu, 1'b1, 64, 8'h5a);
        wait_idle();
        check("cpu write latency", latency(ch_cpu), lone_latency);
        tick();
        issue(ch_cpu, 1'b0, 64, 8'h00);
        wait_idle();
        check("cpu read latency", latency(ch_cpu), lone_latency);
        tick();
        issue(ch_ppu, 1'b0, 64, 8'h00);
        wait_idle();
        check("ppu read latency", latency(ch_ppu), lone_latency);

        // mixed traffic with m2 toggling.
        while (rand_issued < n_rand_ops) begin
            tick();
            if (m2_cnt == 0) begin
                rng = xorshift32(rng);
                m2 <= ~m2;
                m2_cnt = 2 + int'(rng[3:0] % 10);
            end else begin
                m2_cnt--;
            end
            for (int c = 0; c < num_ch; c++) begin
                if (!outstanding[c]) begin
                    rng = xorshift32(rng);
                    if (rng[3:2] == 2'b00) begin
                        if (rng[0]) begin
                            // each channel owns every third address.
                            a = ram_addr_bits'((rng[19:16] % 10) * 3 + c);
                            if (wr_out[a] == 0 && rd_out[a] == 0) begin
                                issue(c, 1'b1, a, rng[31:24]);
                                rand_issued++;
                            end
                        end else begin
                            a = ram_addr_bits'(rng[12:8]);
                            if (written[a] && wr_out[a] == 0) begin
                                issue(c, 1'b0, a, 8'h00);
                                rand_issued++;
                            end
                        end
                    end
                end
            end
        end

        // all three at once come out in priority order.
        settle();
        for (int c = 0; c < num_ch; c++) begin
            issue(c, 1'b1, ram_addr_bits'(96 + c), 8'hc0 + 8'(c));
        end
        wait_idle();
        check("cpu latency in burst", latency(ch_cpu), lone_latency);
        check("ppu after cpu", done_cyc[ch_ppu] - done_cyc[ch_cpu], access_cycles + 1);
        check("api after ppu", done_cyc[ch_api] - done_cyc[ch_ppu], access_cycles + 1);

        // m2 falls just before the request.
        settle();
        m2 <= 1'b0;
        repeat (3) tick();
        issue(ch_api, 1'b0, 96, 8'h00);
        wait_idle();
        check("refresh delayed latency bounded",
              latency(ch_api) > lone_latency &&
              latency(ch_api) <= lone_latency + refresh_cycles + 3, 1);
        settle();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tb/fcart_mem_asserts.sv
module fcart_mem_asserts
    import fcart_pkg::*;
(
    input logic              clk,
    input logic              async_nreset,
    input logic [num_ch-1:0] req,
    input logic [num_ch-1:0] busy,
    input logic [num_ch-1:0] done
);

    for (genvar c = 0; c < num_ch; c++) begin : gen_ch
        // client must wait for done before the next req.
        no_req_busy: assert property (@(posedge clk) disable iff (!async_nreset)
            !(req[c] && busy[c]))
            else $error("channel %0d pulsed req while busy", c);

        done_pulse: assert property (@(posedge clk) disable iff (!async_nreset)
            done[c] |=> !done[c])
            else $error("done on channel %0d held longer than one cycle", c);
    end

    one_done: assert property (@(posedge clk) disable iff (!async_nreset)
        $onehot0(done))
        else $error("more than one done in the same cycle");

    reset_idle: assert property (@(posedge clk)
        !async_nreset |=> (busy == '0 && done == '0))
        else $error("busy or done high after reset");

endmodule

bind fcart_mem fcart_mem_asserts i_asserts (
    .clk         (clk),
    .async_nreset(async_nreset),
    .req         (req),
    .busy        (busy),
    .done        (done)
);

// File: rtl/fcart_mem.sv
module fcart_mem
    import fcart_pkg::*;
(
    input  logic              clk,
    input  logic              async_nreset,
    input  logic              m2,

    input  logic [num_ch-1:0] req,
    input  mem_req_t          req_data [num_ch],
    output logic [num_ch-1:0] done,
    output logic [num_ch-1:0] busy,
    output logic [7:0]        rdata [num_ch]
);

    logic [num_ch-1:0] pending;
    mem_req_t          held [num_ch];
    logic [num_ch-1:0] grant_done;
    logic              mem_en;
    mem_req_t          mem_req;
    logic [7:0]        rd_byte;  // shared by all slots.

    for (genvar c = 0; c < num_ch; c++) begin : gen_slot
        chan_slot i_slot (
            .clk         (clk),
            .async_nreset(async_nreset),
            .req         (req[c]),
            .req_data    (req_data[c]),
            .busy        (busy[c]),
            .done        (done[c]),
            .rdata       (rdata[c]),
            .pending     (pending[c]),
            .held        (held[c]),
            .grant_done  (grant_done[c]),
            .rd_byte     (rd_byte)
        );
    end

    mem_arbiter i_arbiter (
        .clk         (clk),
        .async_nreset(async_nreset),
        .m2          (m2),
        .pending     (pending),
        .held        (held),
        .grant_done  (grant_done),
        .mem_en      (mem_en),
        .mem_req     (mem_req)
    );

    mem_array i_array (
        .clk    (clk),
        .en     (mem_en),
        .req    (mem_req),
        .rd_byte(rd_byte)
    );

endmodule

// File: rtl/mem_array.sv
module mem_array
    import fcart_pkg::*;
(
    input  logic       clk,
    input  logic       en,
    input  mem_req_t   req,
    output logic [7:0] rd_byte
);

    localparam int unsigned depth = 2 ** ram_addr_bits;

    // contents survive reset, like the sdram.
    logic [7:0] mem [depth];

    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rd_byte <= mem[req.addr];  // held until next read.
            end
        end
    end

endmodule

// File: rtl/mem_arbiter.sv
module mem_arbiter
    import fcart_pkg::*;
(
    input  logic              clk,
    input  logic              async_nreset,
    input  logic              m2,

    input  logic [num_ch-1:0] pending,
    input  mem_req_t          held [num_ch],
    output logic [num_ch-1:0] grant_done,

    output logic              mem_en,
    output mem_req_t          mem_req
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_refresh
    } state_t;

    state_t                  state;
    logic [win_cnt_bits-1:0] cnt;
    logic [2:0]              m2_sync;
    logic                    m2_fall;
    logic                    refresh_pend;
    logic [num_ch-1:0]       grant_oh;
    logic [num_ch-1:0]       req_eff;
    logic [num_ch-1:0]       pick;
    mem_req_t                pick_req;
    logic                    grant_go;

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            m2_sync <= '0;
        end else begin
            m2_sync <= {m2_sync[1:0], m2};
        end
    end

    // console bus cycle just ended.
    assign m2_fall = m2_sync[2] && !m2_sync[1];

    // a slot still shows pending in its grant_done cycle.
    assign req_eff = pending & ~grant_done;

    always_comb begin
        pick = '0;
        if (req_eff[ch_cpu]) begin
            pick[ch_cpu] = 1'b1;
        end else if (req_eff[ch_ppu]) begin
            pick[ch_ppu] = 1'b1;
        end else if (req_eff[ch_api]) begin
            pick[ch_api] = 1'b1;
        end
    end

    always_comb begin
        pick_req = '0;
        for (int i = 0; i < num_ch; i++) begin
            if (pick[i]) begin
                pick_req = held[i];
            end
        end
    end

    assign grant_go = (state == st_idle) && !refresh_pend && (|pick);

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            state        <= st_idle;
            cnt          <= '0;
            grant_oh     <= '0;
            grant_done   <= '0;
            mem_en       <= 1'b0;
            refresh_pend <= 1'b0;
        end else begin
            grant_done <= '0;
            mem_en     <= 1'b0;
            if (m2_fall) begin
                refresh_pend <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (refresh_pend) begin
                        state        <= st_refresh;
                        cnt          <= win_cnt_bits'(refresh_cycles - 1);
                        refresh_pend <= m2_fall;  // keep a fresh edge.
                    end else if (grant_go) begin
                        state    <= st_access;
                        cnt      <= win_cnt_bits'(access_cycles - 1);
                        grant_oh <= pick;
                        mem_en   <= 1'b1;
                    end
                end
                st_access: begin
                    if (cnt == '0) begin
                        state      <= st_idle;
                        grant_done <= grant_oh;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_refresh: begin
                    if (cnt == '0) begin
                        state <= st_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // only sampled by the array while mem_en is high.
    always_ff @(posedge clk) begin
        if (grant_go) begin
            mem_req <= pick_req;
        end
    end

endmodule

// File: rtl/chan_slot.sv
module chan_slot
    import fcart_pkg::*;
(
    input  logic       clk,
    input  logic       async_nreset,

    // client side
    input  logic       req,
    input  mem_req_t   req_data,
    output logic       busy,
    output logic       done,
    output logic [7:0] rdata,

    // arbiter side
    output logic       pending,
    output mem_req_t   held,
    input  logic       grant_done,
    input  logic [7:0] rd_byte
);

    logic accept;

    // a req during busy is dropped.
    assign accept = req && !busy;

    // stays up through the done cycle.
    assign busy = pending || done;

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= grant_done;
            if (grant_done) begin
                pending <= 1'b0;
            end else if (accept) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= req_data;
        end
    end

    // array output is stable since the read cycle.
    always_ff @(posedge clk) begin
        if (grant_done) begin
            rdata <= rd_byte;
        end
    end

endmodule

// File: rtl/fcart_pkg.sv
package fcart_pkg;

    // memory clients, index order is also the grant priority.
    localparam int unsigned num_ch = 3;
    localparam int unsigned ch_cpu = 0;  // prg side.
    localparam int unsigned ch_ppu = 1;  // chr side.
    localparam int unsigned ch_api = 2;  // loader.

    // byte address width of the stand-in array.
    localparam int unsigned ram_addr_bits = 10;

    // window lengths in clk cycles.
    localparam int unsigned access_cycles = 3;
    localparam int unsigned refresh_cycles = 4;

    // wide enough for the longer window minus one.
    localparam int unsigned win_cnt_bits = 2;

    typedef struct packed {
        logic [ram_addr_bits-1:0] addr;
        logic [7:0]               wdata;
        logic                     we;     // high for a write.
    } mem_req_t;

endpackage
